// File: verilog.f
+incdir+.
memCtrlPkg.sv
byteStageCounter.sv
byteLaneDatapath.sv
memArbiterFsm.sv
memCtrlTop.sv
tbByteRam.sv
tbMemCtrl.sv

// File: runSim.sh
#!/usr/bin/env bash
# builds and runs the memory controller testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tbMemCtrl \
    -Mdir obj_dir -o simMemCtrl > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/simMemCtrl > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: tbMemCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_config.svh"

module tbMemCtrl
    import memCtrlPkg::*;
();

    localparam int RandomXfers = 250;
    localparam int DirectedXfers = 50;
    localparam int MaxXferCycles = 20;
    localparam int CycleLimit = (RandomXfers + DirectedXfers) * MaxXferCycles;
    localparam int KindFetch = 0;
    localparam int KindLoad = 1;
    localparam int KindStore = 2;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      ioBufferFull;
    logic      fetchEn;
    memAddr_t  fetchAddr;
    logic      fetchDone;
    memWord_t  fetchInst;
    logic      dataEn;
    logic      dataStore;
    memLen_t   dataLen;
    memAddr_t  dataAddr;
    memWord_t  dataWdata;
    logic      dataDone;
    memWord_t  dataRdata;
    memByte_t  memDin;
    memAddr_t  memAddr;
    memByte_t  memDout;
    logic      memWr;
    memOwner_t owner;
    logic      ramEn;

    memByte_t shadow [65536];
    int       errCount;
    int       testCount;
    int       failedTests;
    int       testErrStart;
    int       cycleCount;

    memCtrlTop uut (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .memDin(memDin),
        .memAddr(memAddr),
        .memDout(memDout),
        .memWr(memWr),
        .owner(owner)
    );

    assign ramEn = rdy && !ioBufferFull;

    tbByteRam ram (
        .clk(clk),
        .en(ramEn),
        .wr(memWr),
        .addr(memAddr),
        .din(memDout),
        .dout(memDin)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: a done pulse never arrived within %0d cycles", CycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // no RAM write may slip through a stall
    assert property (@(posedge clk) disable iff (rst) (!rdy || ioBufferFull) |-> !memWr)
        else reportError("memWr high during a stall");

    task automatic reportError(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        errCount++;
    endtask

    task automatic startTest();
        testErrStart = errCount;
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errCount == testErrStart) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errCount - testErrStart);
        end
    endtask

    // little-endian word from the shadow, zero-extended above n bytes
    function automatic memWord_t shadowWord(input memAddr_t a, input int n);
        memWord_t w;
        memAddr_t p;
        w = '0;
        for (int i = 0; i < n; i++) begin
            p = a + memAddr_t'(i);
            w[i*`MEM_BYTE_W +: `MEM_BYTE_W] = shadow[p[15:0]];
        end
        return w;
    endfunction

    function automatic logic wantStall(input int cyc, input logic [31:0] mask, input int pct);
        return (cyc < 32 && mask[cyc]) || (pct > 0 && int'($urandom_range(99)) < pct);
    endfunction

    task automatic driveStall(input logic on);
        if (!on) begin
            rdy <= 1'b1;
            ioBufferFull <= 1'b0;
        end else if ($urandom_range(1) == 0) begin
            rdy <= 1'b0;
            ioBufferFull <= 1'b0;
        end else begin
            rdy <= 1'b1;
            ioBufferFull <= 1'b1;
        end
    endtask

    task automatic waitIdle();
        @(negedge clk);
        while (owner != OwnerNone) begin
            @(negedge clk);
        end
    endtask

    // store bytes and their neighbours, read through the backdoor
    task automatic checkAround(input memAddr_t a);
        memAddr_t p;
        for (int i = -2; i < 6; i++) begin
            p = a + memAddr_t'(i);
            assert (ram.peek(p[15:0]) == shadow[p[15:0]])
                else reportError($sformatf("RAM byte %h is %h, expected %h",
                    p, ram.peek(p[15:0]), shadow[p[15:0]]));
        end
    endtask

    task automatic runXfer(input int kind, input memAddr_t addr, input int n,
                           input memWord_t wdata, input logic [31:0] mask, input int pct);
        int        expCycles;
        int        unstalled;
        int        writes;
        int        cyc;
        logic      done;
        logic      seen;
        memWord_t  expWord;
        memWord_t  result;
        memOwner_t expOwner;
        memAddr_t  p;
        expWord = shadowWord(addr, (kind == KindFetch) ? `FETCH_BYTES : n);
        expOwner = (kind == KindFetch) ? OwnerFetch : OwnerData;
        if (kind == KindFetch) begin
            expCycles = `FETCH_BYTES + 2;
        end else if (kind == KindLoad) begin
            expCycles = n + 2;
        end else begin
            expCycles = n + 1;
        end
        unstalled = 0;
        writes = 0;
        cyc = 0;
        seen = 1'b0;
        @(posedge clk);
        fetchEn <= (kind == KindFetch);
        fetchAddr <= addr;
        dataEn <= (kind != KindFetch);
        dataStore <= (kind == KindStore);
        dataLen <= memLen_t'(n);
        dataAddr <= addr;
        dataWdata <= wdata;
        driveStall(wantStall(0, mask, pct));
        while (!seen) begin
            @(negedge clk);
            done = (kind == KindFetch) ? fetchDone : dataDone;
            result = (kind == KindFetch) ? fetchInst : dataRdata;
            if (memWr) begin
                writes++;
            end
            assert (done == (unstalled == expCycles))
                else reportError($sformatf("done is %0b after %0d active cycles, expected at %0d",
                    done, unstalled, expCycles));
            assert (owner == ((unstalled == 0) ? OwnerNone : expOwner))
                else reportError($sformatf("owner %s after %0d active cycles",
                    owner.name(), unstalled));
            if (done) begin
                seen = 1'b1;
                if (kind != KindStore) begin
                    assert (result == expWord)
                        else reportError($sformatf("read %h at %h, expected %h",
                            result, addr, expWord));
                end
            end
            if (rdy && !ioBufferFull) begin
                unstalled++;
            end
            cyc++;
            @(posedge clk);
            if (seen) begin
                fetchEn <= 1'b0;
                dataEn <= 1'b0;
                driveStall(1'b0);
            end else begin
                driveStall(wantStall(cyc, mask, pct));
            end
        end
        if (kind == KindStore) begin
            assert (writes == n)
                else reportError($sformatf("%0d RAM writes for a %0d byte store", writes, n));
            for (int i = 0; i < n; i++) begin
                p = addr + memAddr_t'(i);
                shadow[p[15:0]] = wdata[i*`MEM_BYTE_W +: `MEM_BYTE_W];
            end
        end else begin
            assert (writes == 0) else reportError("RAM written during a read");
        end
        waitIdle();
        if (kind == KindStore) begin
            checkAround(addr);
        end
    endtask

    // both requesters raise their enable in the same cycle
    task automatic runBoth(input memAddr_t fAddr, input memAddr_t dAddr);
        memWord_t expF;
        memWord_t expD;
        int       cyc;
        int       dataCyc;
        int       fetchCyc;
        expF = shadowWord(fAddr, `FETCH_BYTES);
        expD = shadowWord(dAddr, 4);
        cyc = 0;
        dataCyc = -1;
        fetchCyc = -1;
        @(posedge clk);
        fetchEn <= 1'b1;
        fetchAddr <= fAddr;
        dataEn <= 1'b1;
        dataStore <= 1'b0;
        dataLen <= memLen_t'(4);
        dataAddr <= dAddr;
        driveStall(1'b0);
        while (fetchCyc < 0) begin
            @(negedge clk);
            if (dataDone && dataCyc < 0) begin
                dataCyc = cyc;
                assert (dataRdata == expD)
                    else reportError($sformatf("load %h, expected %h", dataRdata, expD));
            end
            if (fetchDone) begin
                fetchCyc = cyc;
                assert (fetchInst == expF)
                    else reportError($sformatf("fetch %h, expected %h", fetchInst, expF));
            end
            @(posedge clk);
            if (dataCyc == cyc) begin
                dataEn <= 1'b0;
            end
            if (fetchCyc == cyc) begin
                fetchEn <= 1'b0;
            end
            cyc++;
        end
        assert (dataCyc == 6 && fetchCyc == dataCyc + 7)
            else reportError($sformatf("dataDone in cycle %0d, fetchDone in cycle %0d",
                dataCyc, fetchCyc));
        waitIdle();
    endtask

    initial begin
        int       lens [3] = '{1, 2, 4};
        int       kind;
        memByte_t b;
        memAddr_t a;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        errCount = 0;
        testCount = 0;
        failedTests = 0;
        testErrStart = 0;
        cycleCount = 0;
        void'($urandom(32'h5e43));
        for (int i = 0; i < 65536; i++) begin
            b = memByte_t'($urandom);
            ram.preload(16'(i), b);
            shadow[i] = b;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        startTest();
        @(negedge clk);
        assert (!fetchDone && !dataDone && !memWr && owner == OwnerNone)
            else reportError("outputs not idle after reset");
        runXfer(KindFetch, $urandom, 4, '0, '0, 0);
        endTest("reset and fetch");

        startTest();
        foreach (lens[i]) begin
            runXfer(KindLoad, $urandom, lens[i], '0, '0, 0);
        end
        endTest("loads");

        startTest();
        foreach (lens[i]) begin
            a = $urandom;
            runXfer(KindStore, a, lens[i], $urandom, '0, 0);
            runXfer(KindLoad, a, 4, '0, '0, 0);
        end
        endTest("stores");

        startTest();
        runBoth($urandom, $urandom);
        endTest("data before fetch");

        startTest();
        a = $urandom;
        runXfer(KindLoad, a, 4, '0, 32'h0000_0006, 0);
        runXfer(KindStore, a, 4, $urandom, 32'h0000_000c, 0);
        runXfer(KindLoad, a, 4, '0, 32'h0000_0011, 0);
        runXfer(KindFetch, a, 4, '0, 32'h0000_0038, 0);
        for (int i = 0; i < 10; i++) begin
            runXfer(int'($urandom_range(2)), $urandom, lens[$urandom_range(2)],
                $urandom, '0, 40);
        end
        endTest("stalls");

        startTest();
        for (int i = 0; i < RandomXfers; i++) begin
            kind = int'($urandom_range(2));
            runXfer(kind, $urandom, lens[$urandom_range(2)], $urandom, '0, 25);
        end
        endTest("random mix");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
            testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tbByteRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_config.svh"

module tbByteRam
    import memCtrlPkg::*;
(
    input  wire logic     clk,
    input  wire logic     en,
    input  wire logic     wr,
    input  wire memAddr_t addr,
    input  wire memByte_t din,
    output memByte_t      dout
);

    localparam int Depth = 65536;

    memByte_t    cells [Depth];
    logic [15:0] idx;

    assign idx = addr[15:0];

    // read port freezes with the rest of the system during a stall
    always @(posedge clk) begin
        if (en) begin
            dout <= cells[idx];
        end
        if (wr) begin
            cells[idx] = din;
        end
    end

    task automatic preload(input logic [15:0] a, input memByte_t b);
        cells[a] = b;
    endtask

    // backdoor read
    function automatic memByte_t peek(input logic [15:0] a);
        return cells[a];
    endfunction

endmodule

`default_nettype wire

// File: memCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlTop
    import memCtrlPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     rdy,
    input  wire logic     ioBufferFull,
    // instruction fetch
    input  wire logic     fetchEn,
    input  wire memAddr_t fetchAddr,
    output logic          fetchDone,
    output memWord_t      fetchInst,
    // load/store
    input  wire logic     dataEn,
    input  wire logic     dataStore,
    input  wire memLen_t  dataLen,
    input  wire memAddr_t dataAddr,
    input  wire memWord_t dataWdata,
    output logic          dataDone,
    output memWord_t      dataRdata,
    // byte RAM
    input  wire memByte_t memDin,
    output memAddr_t      memAddr,
    output memByte_t      memDout,
    output logic          memWr,
    output memOwner_t     owner
);

    logic     stageClear;
    logic     stageRun;
    memLen_t  xferLen;
    memLen_t  stage;
    logic     lastStage;
    memAddr_t baseAddr;
    memWord_t storeWord;
    logic     isWrite;
    logic     byteCapture;
    memWord_t assembledWord;

    memArbiterFsm fsm (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .lastStage(lastStage),
        .assembledWord(assembledWord),
        .stageClear(stageClear),
        .stageRun(stageRun),
        .xferLen(xferLen),
        .baseAddr(baseAddr),
        .storeWord(storeWord),
        .isWrite(isWrite),
        .byteCapture(byteCapture),
        .memWr(memWr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .owner(owner)
    );

    byteStageCounter stageCnt (
        .clk(clk),
        .rst(rst),
        .clear(stageClear),
        .run(stageRun),
        .len(xferLen),
        .stage(stage),
        .lastStage(lastStage)
    );

    byteLaneDatapath lanePath (
        .clk(clk),
        .rst(rst),
        .baseAddr(baseAddr),
        .storeWord(storeWord),
        .stage(stage),
        .xferLen(xferLen),
        .isWrite(isWrite),
        .byteCapture(byteCapture),
        .memDin(memDin),
        .memAddr(memAddr),
        .memDout(memDout),
        .assembledWord(assembledWord)
    );

endmodule

`default_nettype wire

// File: memArbiterFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_config.svh"

module memArbiterFsm
    import memCtrlPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     rdy,
    input  wire logic     ioBufferFull,
    input  wire logic     fetchEn,
    input  wire memAddr_t fetchAddr,
    input  wire logic     dataEn,
    input  wire logic     dataStore,
    input  wire memLen_t  dataLen,
    input  wire memAddr_t dataAddr,
    input  wire memWord_t dataWdata,
    input  wire logic     lastStage,
    input  wire memWord_t assembledWord,
    output logic          stageClear,
    output logic          stageRun,
    output memLen_t       xferLen,
    output memAddr_t      baseAddr,
    output memWord_t      storeWord,
    output logic          isWrite,
    output logic          byteCapture,
    output logic          memWr,
    output logic          fetchDone,
    output memWord_t      fetchInst,
    output logic          dataDone,
    output memWord_t      dataRdata,
    output memOwner_t     owner
);

    ctrlState_t state;
    logic       stall;
    logic       busy;

    assign stall = !rdy || ioBufferFull;
    assign busy = (state == ReadInst) || (state == ReadData) || (state == WriteData);

    assign isWrite = (state == WriteData);
    assign stageClear = (state == Idle) && !stall;
    assign stageRun = busy && !stall;
    assign byteCapture = busy && !stall;
    assign memWr = isWrite && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            owner <= OwnerNone;
            xferLen <= '0;
            fetchDone <= 1'b0;
            dataDone <= 1'b0;
        end else if (!stall) begin
            case (state)
                Idle: begin
                    // data port wins
                    if (dataEn) begin
                        state <= dataStore ? WriteData : ReadData;
                        owner <= OwnerData;
                        // stores end on their last byte, reads one later
                        xferLen <= dataStore ? dataLen - memLen_t'(1) : dataLen;
                    end else if (fetchEn) begin
                        state <= ReadInst;
                        owner <= OwnerFetch;
                        xferLen <= memLen_t'(`FETCH_BYTES);
                    end
                end
                ReadInst, ReadData: begin
                    if (lastStage) begin
                        state <= Done;
                        fetchDone <= (state == ReadInst);
                        dataDone <= (state == ReadData);
                    end
                end
                WriteData: begin
                    if (lastStage) begin
                        state <= Done;
                        dataDone <= 1'b1;
                    end
                end
                Done: begin
                    state <= Idle;
                    owner <= OwnerNone;
                    fetchDone <= 1'b0;
                    dataDone <= 1'b0;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // request fields and results
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == Idle) begin
                if (dataEn) begin
                    baseAddr <= dataAddr;
                    storeWord <= dataWdata;
                end else if (fetchEn) begin
                    baseAddr <= fetchAddr;
                end
            end
            if (lastStage && (state == ReadInst)) begin
                fetchInst <= assembledWord;
            end
            if (lastStage && (state == ReadData)) begin
                dataRdata <= assembledWord;
            end
        end
    end

endmodule

`default_nettype wire

// File: byteLaneDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "memCtrl_config.svh"

module byteLaneDatapath
    import memCtrlPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire memAddr_t baseAddr,
    input  wire memWord_t storeWord,
    input  wire memLen_t  stage,
    input  wire memLen_t  xferLen,
    input  wire logic     isWrite,
    input  wire logic     byteCapture,
    input  wire memByte_t memDin,
    output memAddr_t      memAddr,
    output memByte_t      memDout,
    output memWord_t      assembledWord
);

    memByte_t lanes [`MEM_LANES];
    logic     readCapture;
    memLen_t  prevStage;

    assign memAddr = baseAddr + memAddr_t'(stage);

    // read data lags its address by one cycle
    assign readCapture = byteCapture && !isWrite && (stage != '0);
    assign prevStage = stage - memLen_t'(1);

    // store byte for the current stage
    always_comb begin
        memDout = '0;
        if (byteCapture && isWrite) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (stage == memLen_t'(i)) begin
                    memDout = storeWord[i*`MEM_BYTE_W +: `MEM_BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                lanes[i] <= '0;
            end
        end else if (readCapture) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (prevStage == memLen_t'(i)) begin
                    lanes[i] <= memDin;
                end
            end
        end
    end

    // the byte arriving now is merged in, so the FSM can latch the full
    // word on the same edge that captures the last byte
    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            if (memLen_t'(i) >= xferLen) begin
                // zero extension
                assembledWord[i*`MEM_BYTE_W +: `MEM_BYTE_W] = '0;
            end else if (readCapture && (prevStage == memLen_t'(i))) begin
                assembledWord[i*`MEM_BYTE_W +: `MEM_BYTE_W] = memDin;
            end else begin
                assembledWord[i*`MEM_BYTE_W +: `MEM_BYTE_W] = lanes[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: byteStageCounter.sv
`timescale 1ns/1ps
`default_nettype none

module byteStageCounter
    import memCtrlPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    clear,
    input  wire logic    run,
    input  wire memLen_t len,
    output memLen_t      stage,
    output logic         lastStage
);

    // byte index of the transfer in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (clear) begin
            stage <= '0;
        end else if (run) begin
            stage <= stage + memLen_t'(1);
        end
    end

    // len is the final stage the FSM waits for
    assign lastStage = (stage == len);

endmodule

`default_nettype wire

// File: memCtrlPkg.sv
`default_nettype none

`include "memCtrl_config.svh"

package memCtrlPkg;

    typedef logic [`MEM_ADDR_W-1:0] memAddr_t;

    typedef logic [`MEM_WORD_W-1:0] memWord_t;

    typedef logic [`MEM_BYTE_W-1:0] memByte_t;

    // byte count of a request, or the index of the current byte
    typedef logic [`MEM_LEN_W-1:0] memLen_t;

    typedef enum logic [2:0] {
        Idle,
        ReadInst,
        ReadData,
        WriteData,
        Done
    } ctrlState_t;

    // who holds the RAM right now
    typedef enum logic [1:0] {
        OwnerNone,
        OwnerFetch,
        OwnerData
    } memOwner_t;

endpackage

`default_nettype wire

// File: memCtrl_config.svh
`ifndef MEM_CTRL_CONFIG_SVH
`define MEM_CTRL_CONFIG_SVH

// byte address into the RAM
`define MEM_ADDR_W 32

// request and result word of both requesters
`define MEM_WORD_W 32

// the RAM moves one byte per cycle
`define MEM_BYTE_W 8

// holds a byte count or a byte index, 0 to 4
`define MEM_LEN_W 3

// one instruction
`define FETCH_BYTES 4

// byte lanes in a word
`define MEM_LANES (`MEM_WORD_W / `MEM_BYTE_W)

`endif
